//--- mylstar_pkg.sv
`default_nettype none

package mylstar_pkg;

  // Raster
  localparam int h_total     = 318;
  localparam int h_active    = 256;
  localparam int v_total     = 256;
  localparam int v_active    = 240;
  localparam int hsync_start = 272;
  localparam int hsync_len   = 32;
  localparam int vsync_start = 244;
  localparam int vsync_len   = 4;

  // Widths
  localparam int coord_w = 8;
  localparam int pix_w   = 4;
  localparam int map_aw  = 10;
  localparam int rom_aw  = 13;
  localparam int host_aw = 10;
  localparam int host_dw = 8;

  // Pixel enables from coordinate to layer pixel
  localparam int layer_lat = 2;

  // Host write targets
  localparam logic [1:0] tgt_map = 2'd0;
  localparam logic [1:0] tgt_fg  = 2'd1;
  localparam logic [1:0] tgt_pal = 2'd2;

  // Palette write word, view picked by host address bit 4
  typedef union packed {
    struct packed {
      logic [3:0] green;
      logic [3:0] blue;
    } gb;
    struct packed {
      logic [3:0] unused;
      logic [3:0] red;
    } xr;
  } palette_word_u;

endpackage

`default_nettype wire

//--- video_timing.sv
`default_nettype none
`timescale 1ns/10ps

module video_timing (
  input  logic       clk_sys,
  input  logic       arst_n,
  input  logic       pix_ce,
  input  logic       flip,
  output logic [8:0] h_pos,
  output logic [mylstar_pkg::coord_w-1:0] v_pos,
  output logic [mylstar_pkg::coord_w-1:0] hh,
  output logic [mylstar_pkg::coord_w-1:0] vv,
  output logic       hblank,
  output logic       vblank,
  output logic       hsync,
  output logic       vsync
);

  logic h_last;
  logic v_last;

  assign h_last = (h_pos == 9'(mylstar_pkg::h_total - 1));
  assign v_last = (v_pos == 8'(mylstar_pkg::v_total - 1));

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (pix_ce) begin
      if (h_last) begin
        h_pos <= '0;
        // Line counter steps at end of each line
        if (v_last) begin
          v_pos <= '0;
        end else begin
          v_pos <= v_pos + 1'b1;
        end
      end else begin
        h_pos <= h_pos + 1'b1;
      end
    end
  end

  assign hblank = (h_pos >= 9'(mylstar_pkg::h_active));
  assign vblank = (v_pos >= 8'(mylstar_pkg::v_active));

  assign hsync = (h_pos >= 9'(mylstar_pkg::hsync_start)) &&
                 (h_pos < 9'(mylstar_pkg::hsync_start + mylstar_pkg::hsync_len));
  assign vsync = (v_pos >= 8'(mylstar_pkg::vsync_start)) &&
                 (v_pos < 8'(mylstar_pkg::vsync_start + mylstar_pkg::vsync_len));

  // Layer coordinates, mirrored like the XOR gates on the board
  assign hh = h_pos[7:0] ^ {mylstar_pkg::coord_w{flip}};
  assign vv = v_pos ^ {mylstar_pkg::coord_w{flip}};

endmodule

`default_nettype wire

//--- bg_tile_layer.sv
`default_nettype none
`timescale 1ns/10ps

module bg_tile_layer (
  input  logic                              clk_sys,
  input  logic                              arst_n,
  input  logic                              pix_ce,
  input  logic [mylstar_pkg::coord_w-1:0]   hh,
  input  logic [mylstar_pkg::coord_w-1:0]   vv,
  input  logic                              host_we,
  input  logic [1:0]                        host_tgt,
  input  logic [mylstar_pkg::host_aw-1:0]   host_addr,
  input  logic [mylstar_pkg::host_dw-1:0]   host_data,
  input  logic                              rom_init,
  input  logic [mylstar_pkg::rom_aw-1:0]    rom_init_address,
  input  logic [7:0]                        rom_init_data,
  output logic [mylstar_pkg::pix_w-1:0]     bg_pix
);

  logic [7:0] map_ram  [0:(1 << mylstar_pkg::map_aw) - 1];
  logic [7:0] tile_rom [0:(1 << mylstar_pkg::rom_aw) - 1];

  logic [mylstar_pkg::map_aw-1:0] map_rd_addr;
  logic [mylstar_pkg::rom_aw-1:0] rom_rd_addr;
  logic [7:0] map_q;
  logic [2:0] s1_row;
  logic [2:0] s1_col;
  logic [7:0] rom_q;
  logic       s2_odd;

  always_ff @(posedge clk_sys) begin
    if (host_we && host_tgt == mylstar_pkg::tgt_map) begin
      map_ram[host_addr] <= host_data;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (rom_init) begin
      tile_rom[rom_init_address] <= rom_init_data;
    end
  end

  // Tile row over tile column
  assign map_rd_addr = {vv[7:3], hh[7:3]};

  // Bank, code, pixel row, byte within the row
  assign rom_rd_addr = {map_q[7], map_q[6:0], s1_row, s1_col[2:1]};

  // Stage 1: tile map entry
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      map_q  <= '0;
      s1_row <= '0;
      s1_col <= '0;
    end else if (pix_ce) begin
      map_q  <= map_ram[map_rd_addr];
      s1_row <= vv[2:0];
      s1_col <= hh[2:0];
    end
  end

  // Stage 2: graphics byte, two pixels
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      rom_q  <= '0;
      s2_odd <= 1'b0;
    end else if (pix_ce) begin
      rom_q  <= tile_rom[rom_rd_addr];
      s2_odd <= s1_col[0];
    end
  end

  // Even pixel in the high nibble
  assign bg_pix = s2_odd ? rom_q[3:0] : rom_q[7:4];

endmodule

`default_nettype wire

//--- fg_line_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module fg_line_buffer (
  input  logic                            clk_sys,
  input  logic                            arst_n,
  input  logic                            pix_ce,
  input  logic [mylstar_pkg::coord_w-1:0] hh,
  input  logic                            line_odd,
  input  logic                            hblank,
  input  logic                            host_we,
  input  logic [1:0]                      host_tgt,
  input  logic [mylstar_pkg::host_aw-1:0] host_addr,
  input  logic [mylstar_pkg::host_dw-1:0] host_data,
  output logic [mylstar_pkg::pix_w-1:0]   fg_pix
);

  logic [mylstar_pkg::pix_w-1:0] lb [0:1][0:255];

  logic [7:0] rd_x;
  logic       rd_sel;
  logic       rd_act;
  logic       host_hit;
  logic [1:0] host_wr;
  logic [1:0] clr_we;
  logic [mylstar_pkg::pix_w-1:0] fg_q;

  assign host_hit = host_we && host_tgt == mylstar_pkg::tgt_fg;

  // Host fills the buffer that is not on display
  assign host_wr = host_hit ? (line_odd ? 2'b01 : 2'b10) : 2'b00;

  // Erase behind the beam during active video
  assign clr_we = (pix_ce && rd_act) ? (rd_sel ? 2'b10 : 2'b01) : 2'b00;

  always_ff @(posedge clk_sys) begin
    for (int b = 0; b < 2; b++) begin
      if (clr_we[b]) begin
        lb[b][rd_x] <= '0;
      end else if (host_wr[b]) begin
        lb[b][host_addr[7:0]] <= host_data[3:0];
      end
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      rd_x   <= '0;
      rd_sel <= 1'b0;
      rd_act <= 1'b0;
    end else if (pix_ce) begin
      rd_x   <= hh;
      rd_sel <= line_odd;
      rd_act <= ~hblank;
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      fg_q <= '0;
    end else if (pix_ce) begin
      fg_q <= lb[rd_sel][rd_x];
    end
  end

  assign fg_pix = fg_q;

endmodule

`default_nettype wire

//--- pixel_mixer.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_mixer (
  input  logic                            clk_sys,
  input  logic                            arst_n,
  input  logic                            pix_ce,
  input  logic [mylstar_pkg::pix_w-1:0]   bg_pix,
  input  logic [mylstar_pkg::pix_w-1:0]   fg_pix,
  input  logic                            fb_priority,
  input  logic                            hblank,
  input  logic                            vblank,
  input  logic                            hsync,
  input  logic                            vsync,
  input  logic                            host_we,
  input  logic [1:0]                      host_tgt,
  input  logic [mylstar_pkg::host_aw-1:0] host_addr,
  input  logic [mylstar_pkg::host_dw-1:0] host_data,
  output logic [7:0]                      red,
  output logic [7:0]                      green,
  output logic [7:0]                      blue,
  output logic                            hblank_out,
  output logic                            vblank_out,
  output logic                            hsync_out,
  output logic                            vsync_out
);

  logic [3:0] pal_red   [0:15];
  logic [3:0] pal_green [0:15];
  logic [3:0] pal_blue  [0:15];

  mylstar_pkg::palette_word_u pal_word;
  logic                          pick_fg;
  logic [mylstar_pkg::pix_w-1:0] idx;
  logic [3:0] t_pipe [0:mylstar_pkg::layer_lat-1];
  logic [3:0] t_al;
  logic       blank;

  assign pal_word = host_data;

  always_ff @(posedge clk_sys) begin
    if (host_we && host_tgt == mylstar_pkg::tgt_pal) begin
      if (host_addr[4]) begin
        pal_red[host_addr[3:0]] <= pal_word.xr.red;
      end else begin
        pal_green[host_addr[3:0]] <= pal_word.gb.green;
        pal_blue[host_addr[3:0]]  <= pal_word.gb.blue;
      end
    end
  end

  // Zero pixel is transparent on either layer
  assign pick_fg = fb_priority ? (bg_pix == '0) : (fg_pix != '0);
  assign idx     = pick_fg ? fg_pix : bg_pix;

  // Timing levels wait for the layer pipeline
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < mylstar_pkg::layer_lat; i++) begin
        t_pipe[i] <= '0;
      end
    end else if (pix_ce) begin
      t_pipe[0] <= {hblank, vblank, hsync, vsync};
      for (int i = 1; i < mylstar_pkg::layer_lat; i++) begin
        t_pipe[i] <= t_pipe[i-1];
      end
    end
  end

  assign t_al  = t_pipe[mylstar_pkg::layer_lat-1];
  assign blank = t_al[3] | t_al[2];

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
      {hblank_out, vblank_out, hsync_out, vsync_out} <= '0;
    end else if (pix_ce) begin
      red   <= blank ? 8'h00 : {pal_red[idx], 4'h0};
      green <= blank ? 8'h00 : {pal_green[idx], 4'h0};
      blue  <= blank ? 8'h00 : {pal_blue[idx], 4'h0};
      {hblank_out, vblank_out, hsync_out, vsync_out} <= t_al;
    end
  end

endmodule

`default_nettype wire

//--- mylstar_video.sv
`default_nettype none
`timescale 1ns/10ps

module mylstar_video (
  input  logic                            clk_sys,
  input  logic                            arst_n,
  input  logic                            pix_ce,
  input  logic                            flip,
  input  logic                            fb_priority,
  input  logic                            host_we,
  input  logic [1:0]                      host_tgt,
  input  logic [mylstar_pkg::host_aw-1:0] host_addr,
  input  logic [mylstar_pkg::host_dw-1:0] host_data,
  input  logic                            rom_init,
  input  logic [mylstar_pkg::rom_aw-1:0]  rom_init_address,
  input  logic [7:0]                      rom_init_data,
  output logic [7:0]                      red,
  output logic [7:0]                      green,
  output logic [7:0]                      blue,
  output logic                            hblank,
  output logic                            vblank,
  output logic                            hsync,
  output logic                            vsync
);

  logic [mylstar_pkg::coord_w-1:0] hh;
  logic [mylstar_pkg::coord_w-1:0] vv;
  logic [mylstar_pkg::pix_w-1:0]   bg_pix;
  logic [mylstar_pkg::pix_w-1:0]   fg_pix;
  logic t_hblank;
  logic t_vblank;
  logic t_hsync;
  logic t_vsync;

  video_timing u_timing (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .pix_ce  (pix_ce),
    .flip    (flip),
    .h_pos   (),
    .v_pos   (),
    .hh      (hh),
    .vv      (vv),
    .hblank  (t_hblank),
    .vblank  (t_vblank),
    .hsync   (t_hsync),
    .vsync   (t_vsync)
  );

  bg_tile_layer u_bg (
    .clk_sys          (clk_sys),
    .arst_n           (arst_n),
    .pix_ce           (pix_ce),
    .hh               (hh),
    .vv               (vv),
    .host_we          (host_we),
    .host_tgt         (host_tgt),
    .host_addr        (host_addr),
    .host_data        (host_data),
    .rom_init         (rom_init),
    .rom_init_address (rom_init_address),
    .rom_init_data    (rom_init_data),
    .bg_pix           (bg_pix)
  );

  fg_line_buffer u_fg (
    .clk_sys   (clk_sys),
    .arst_n    (arst_n),
    .pix_ce    (pix_ce),
    .hh        (hh),
    .line_odd  (vv[0]),
    .hblank    (t_hblank),
    .host_we   (host_we),
    .host_tgt  (host_tgt),
    .host_addr (host_addr),
    .host_data (host_data),
    .fg_pix    (fg_pix)
  );

  pixel_mixer u_mix (
    .clk_sys     (clk_sys),
    .arst_n      (arst_n),
    .pix_ce      (pix_ce),
    .bg_pix      (bg_pix),
    .fg_pix      (fg_pix),
    .fb_priority (fb_priority),
    .hblank      (t_hblank),
    .vblank      (t_vblank),
    .hsync       (t_hsync),
    .vsync       (t_vsync),
    .host_we     (host_we),
    .host_tgt    (host_tgt),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hblank_out  (hblank),
    .vblank_out  (vblank),
    .hsync_out   (hsync),
    .vsync_out   (vsync)
  );

endmodule

`default_nettype wire

//--- tb_mylstar_video.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mylstar_video;

  localparam int clk_half    = 4;
  localparam int n_rows      = 9;
  localparam int frame_ns    = mylstar_pkg::h_total * mylstar_pkg::v_total * 4 * clk_half;
  localparam int watchdog_ns = (n_rows * 2 + 6) * frame_ns;

  typedef struct packed {
    logic [7:0] code;
    logic [7:0] rom_byte;
    logic [3:0] fg;
    logic       prio;
    logic       flip;
    logic [7:0] x;
    logic [7:0] y;
    logic [3:0] idx;
  } scene_t;

  // code, ROM byte, fg nibble, priority, flip, screen x, screen y, palette index
  scene_t scenes [n_rows] = '{
    '{8'h12, 8'hA5, 4'h0, 1'b0, 1'b0, 8'd40,  8'd20,  4'hA},
    '{8'h93, 8'h6C, 4'h0, 1'b0, 1'b0, 8'd41,  8'd50,  4'hC},
    '{8'h21, 8'h3B, 4'h7, 1'b0, 1'b0, 8'd64,  8'd75,  4'h7},
    '{8'h21, 8'h3B, 4'h7, 1'b1, 1'b0, 8'd64,  8'd75,  4'h3},
    '{8'h45, 8'h0E, 4'h9, 1'b1, 1'b0, 8'd130, 8'd131, 4'h9},
    '{8'hC7, 8'hD4, 4'h0, 1'b0, 1'b0, 8'd131, 8'd202, 4'h4},
    '{8'h58, 8'h2F, 4'h0, 1'b0, 1'b0, 8'd37,  8'd100, 4'hF},
    '{8'h58, 8'h2F, 4'h0, 1'b0, 1'b1, 8'd218, 8'd155, 4'hF},
    '{8'h58, 8'h2F, 4'h5, 1'b0, 1'b1, 8'd218, 8'd155, 4'h5}
  };

  logic                            clk_sys;
  logic                            arst_n;
  logic                            pix_ce;
  logic                            flip;
  logic                            fb_priority;
  logic                            host_we;
  logic [1:0]                      host_tgt;
  logic [mylstar_pkg::host_aw-1:0] host_addr;
  logic [mylstar_pkg::host_dw-1:0] host_data;
  logic                            rom_init;
  logic [mylstar_pkg::rom_aw-1:0]  rom_init_address;
  logic [7:0]                      rom_init_data;
  logic [7:0]                      red;
  logic [7:0]                      green;
  logic [7:0]                      blue;
  logic                            hblank;
  logic                            vblank;
  logic                            hsync;
  logic                            vsync;

  // Position of the pixel currently on the outputs
  int   pos_x = 0;
  int   pos_y = 0;
  bit   locked = 1'b0;
  logic [7:0] obs_red;
  logic [7:0] obs_green;
  logic [7:0] obs_blue;
  logic prev_hb = 1'b0;
  logic prev_vb = 1'b0;
  logic prev_hs = 1'b0;
  logic prev_vs = 1'b0;

  int ce_run = 0;
  int line_len = 0;
  int line_run = 0;
  int frame_lines = 0;
  int blank_run = 0;
  int blank_lines = 0;
  int hs_run = 0;
  int hs_width = 0;
  int vs_run = 0;
  int vs_width = 0;

  logic [3:0] pal_r [16];
  logic [3:0] pal_g [16];
  logic [3:0] pal_b [16];

  int err_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;

  mylstar_video uut (
    .clk_sys          (clk_sys),
    .arst_n           (arst_n),
    .pix_ce           (pix_ce),
    .flip             (flip),
    .fb_priority      (fb_priority),
    .host_we          (host_we),
    .host_tgt         (host_tgt),
    .host_addr        (host_addr),
    .host_data        (host_data),
    .rom_init         (rom_init),
    .rom_init_address (rom_init_address),
    .rom_init_data    (rom_init_data),
    .red              (red),
    .green            (green),
    .blue             (blue),
    .hblank           (hblank),
    .vblank           (vblank),
    .hsync            (hsync),
    .vsync            (vsync)
  );

  always #(clk_half) clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    pix_ce <= ~pix_ce;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Outputs still hold the previous pixel at this edge
  always @(posedge clk_sys) begin
    if (arst_n && pix_ce) begin
      if (prev_vb && !vblank) begin
        pos_x = 0;
        pos_y = 0;
        locked = 1'b1;
        blank_lines = blank_run;
      end else if (pos_x == mylstar_pkg::h_total - 1) begin
        pos_x = 0;
        pos_y = (pos_y + 1) % mylstar_pkg::v_total;
      end else begin
        pos_x = pos_x + 1;
      end
      obs_red = red;
      obs_green = green;
      obs_blue = blue;
      ce_run++;
      if (hblank && !prev_hb) begin
        line_len = ce_run;
        ce_run = 0;
        line_run++;
        if (vblank) begin
          blank_run++;
        end
      end
      if (vblank && !prev_vb) begin
        frame_lines = line_run;
        line_run = 0;
        blank_run = 0;
      end
      if (hsync) begin
        hs_run++;
      end else if (prev_hs) begin
        hs_width = hs_run;
        hs_run = 0;
      end
      if (vsync) begin
        vs_run++;
      end else if (prev_vs) begin
        vs_width = vs_run;
        vs_run = 0;
      end
      if (hblank || vblank) begin
        check("red while blanked", 32'(red), 32'h0);
        check("green while blanked", 32'(green), 32'h0);
        check("blue while blanked", 32'(blue), 32'h0);
      end
      prev_hb = hblank;
      prev_vb = vblank;
      prev_hs = hsync;
      prev_vs = vsync;
    end
  end

  task automatic wait_pos(input int x, input int y);
    @(negedge clk_sys);
    while (!(locked && pos_x == x && pos_y == y)) begin
      @(negedge clk_sys);
    end
  endtask

  task automatic host_write(input logic [1:0] tgt, input logic [9:0] addr,
                            input logic [7:0] data);
    @(posedge clk_sys);
    host_we   <= 1'b1;
    host_tgt  <= tgt;
    host_addr <= addr;
    host_data <= data;
    @(posedge clk_sys);
    host_we   <= 1'b0;
  endtask

  task automatic rom_write(input logic [12:0] addr, input logic [7:0] data);
    @(posedge clk_sys);
    rom_init         <= 1'b1;
    rom_init_address <= addr;
    rom_init_data    <= data;
    @(posedge clk_sys);
    rom_init         <= 1'b0;
  endtask

  // Both palette views, fresh colors every scene
  task automatic program_palette();
    mylstar_pkg::palette_word_u pw;
    for (int i = 0; i < 16; i++) begin
      pal_r[i] = 4'($urandom);
      pal_g[i] = 4'($urandom);
      pal_b[i] = 4'($urandom);
      pw.gb.green = pal_g[i];
      pw.gb.blue  = pal_b[i];
      host_write(mylstar_pkg::tgt_pal, 10'(i), pw);
      pw.xr.unused = 4'($urandom);
      pw.xr.red    = pal_r[i];
      host_write(mylstar_pkg::tgt_pal, 10'(16 + i), pw);
    end
  endtask

  task automatic check_color(input logic [3:0] e);
    check("red", 32'(obs_red), 32'({pal_r[e], 4'h0}));
    check("green", 32'(obs_green), 32'({pal_g[e], 4'h0}));
    check("blue", 32'(obs_blue), 32'({pal_b[e], 4'h0}));
  endtask

  task automatic report(input string name, input int errs);
    test_cnt++;
    if (err_cnt == errs) begin
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: %0d mismatches", name, err_cnt - errs);
    end
  endtask

  task automatic check_raster();
    int errs;
    errs = err_cnt;
    wait_pos(0, mylstar_pkg::v_active + 10);
    check("pixels per line", line_len, mylstar_pkg::h_total);
    check("lines per frame", frame_lines, mylstar_pkg::v_total);
    check("blank lines", blank_lines, mylstar_pkg::v_total - mylstar_pkg::v_active);
    check("hsync width", hs_width, mylstar_pkg::hsync_len);
    check("vsync width", vs_width, mylstar_pkg::vsync_len * mylstar_pkg::h_total);
    report("raster", errs);
  endtask

  task automatic run_scene(input int n);
    scene_t     sc;
    logic [7:0] lx;
    logic [7:0] ly;
    int         errs;
    sc = scenes[n];
    errs = err_cnt;
    lx = sc.flip ? ~sc.x : sc.x;
    ly = sc.flip ? ~sc.y : sc.y;
    wait_pos(0, mylstar_pkg::v_active);
    @(posedge clk_sys);
    flip        <= sc.flip;
    fb_priority <= sc.prio;
    // Empty tile apart from the one byte under test
    for (int k = 0; k < 32; k++) begin
      rom_write({sc.code, 5'(k)}, 8'h00);
    end
    rom_write({sc.code, ly[2:0], lx[2:1]}, sc.rom_byte);
    host_write(mylstar_pkg::tgt_map, {ly[7:3], lx[7:3]}, sc.code);
    program_palette();
    if (sc.fg != 4'h0) begin
      wait_pos(100, int'(sc.y) - 1);
      host_write(mylstar_pkg::tgt_fg, {2'b00, lx}, {4'h0, sc.fg});
    end
    wait_pos(int'(sc.x), int'(sc.y));
    check_color(sc.idx);
    // Line buffer erased by now, tile row two lines on is empty
    wait_pos(int'(sc.x), int'(sc.y) + 2);
    check_color(4'h0);
    report($sformatf("scene %0d code %h at (%0d,%0d) flip %0d", n, sc.code, sc.x, sc.y,
                     sc.flip), errs);
  endtask

  initial begin
    clk_sys          = 1'b0;
    arst_n           = 1'b0;
    pix_ce           = 1'b0;
    flip             = 1'b0;
    fb_priority      = 1'b0;
    host_we          = 1'b0;
    host_tgt         = 2'b00;
    host_addr        = '0;
    host_data        = '0;
    rom_init         = 1'b0;
    rom_init_address = '0;
    rom_init_data    = '0;
    void'($urandom(40401));
    repeat (5) @(posedge clk_sys);
    arst_n <= 1'b1;
    for (int a = 0; a < (1 << mylstar_pkg::rom_aw); a++) begin
      rom_write(13'(a), 8'((a * 29) ^ (a >> 7)));
    end
    for (int a = 0; a < (1 << mylstar_pkg::map_aw); a++) begin
      host_write(mylstar_pkg::tgt_map, 10'(a), 8'(a ^ (a >> 2)));
    end
    check_raster();
    for (int n = 0; n < n_rows; n++) begin
      run_scene(n);
    end
    $display("tests %0d, failed %0d, mismatches %0d", test_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the scenes did not finish within %0d ns", watchdog_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
mylstar_pkg.sv
video_timing.sv
bg_tile_layer.sv
fg_line_buffer.sv
pixel_mixer.sv
mylstar_video.sv
tb_mylstar_video.sv

//--- Makefile
TOP = tb_mylstar_video

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir
